// File: hdl/lab4d_pkg.sv
package lab4d_pkg;

	////////////////////////////////////////////////////////////////////////////
	// sizes
	////////////////////////////////////////////////////////////////////////////

	localparam int NUM_LAB = 12;
	localparam int SERIAL_W = 24;
	localparam int SERIAL_CNT_W = $clog2(SERIAL_W);
	// selects of NUM_LAB and above address every chip
	localparam int SEL_W = 4;
	localparam int SHIFT_PRESCALE_W = 8;
	localparam int READOUT_PRESCALE_W = 4;
	localparam int EMPTY_SIZE_W = 10;

	localparam logic [SHIFT_PRESCALE_W-1:0] SHIFT_PRESCALE_DEFAULT = '0;
	localparam logic [READOUT_PRESCALE_W-1:0] READOUT_PRESCALE_DEFAULT = '0;

	////////////////////////////////////////////////////////////////////////////
	// encodings
	////////////////////////////////////////////////////////////////////////////

	// word index, wishbone address bits 6:2
	typedef enum logic [4:0] {
		REG_CONTROL          = 5'd0,
		REG_SHIFT_PRESCALE   = 5'd1,
		REG_READOUT_PRESCALE = 5'd2,
		REG_USER_WRITE       = 5'd6,
		REG_READOUT          = 5'd22,
		REG_EMPTY_SIZE       = 5'd23
	} wb_reg_e;

	// sequencer port id, bits 4:0
	typedef enum logic [4:0] {
		PORT_CONTROL     = 5'd0,
		PORT_USER_WRITE0 = 5'd8,
		PORT_USER_WRITE1 = 5'd9,
		PORT_USER_WRITE2 = 5'd10,
		PORT_USER_WRITE3 = 5'd11,
		PORT_SERIAL0     = 5'd16,
		PORT_SERIAL1     = 5'd17,
		PORT_SERIAL2     = 5'd18,
		PORT_SERIAL_CTRL = 5'd19,
		PORT_READOUT     = 5'd22
	} pb_port_e;

	typedef enum logic [1:0] {
		IDLE,
		DATA_LOW,
		DATA_HIGH,
		LOAD
	} shift_state_e;

endpackage

// File: hdl/lab4d_ctrl_if.sv
interface lab4d_ctrl_if;
	import lab4d_pkg::*;

	// owned by the register slave
	logic runmode_request;
	logic reset_request;
	logic [SERIAL_W-1:0] user_write;
	logic [SEL_W-1:0] user_select;
	logic user_write_request;

	// owned by the sequencer port block
	logic runmode;
	logic ctrl_wr;
	logic ctrl_reset_val;
	logic user_req_wr;
	logic user_req_val;
	logic readout_pending;
	logic readout_done;

	modport regs (
		output runmode_request, reset_request, user_write, user_select, user_write_request,
		input  runmode, ctrl_wr, ctrl_reset_val, user_req_wr, user_req_val,
		input  readout_pending, readout_done
	);

	modport seq (
		input  runmode_request, reset_request, user_write, user_select, user_write_request,
		output runmode, ctrl_wr, ctrl_reset_val, user_req_wr, user_req_val,
		output readout_pending, readout_done
	);

endinterface

// File: hdl/lab4d_serial_if.sv
interface lab4d_serial_if;
	import lab4d_pkg::*;

	logic [SERIAL_W-1:0] word;
	logic [SEL_W-1:0] select;
	// single cycle start request
	logic go;
	logic busy;

	modport loader (
		output word, select, go,
		input  busy
	);

	modport shifter (
		input  word, select, go,
		output busy
	);

endinterface

// File: hdl/lab4d_wb_regs.sv
module lab4d_wb_regs (
	input  logic clk_i,
	input  logic rst_n_i,
	input  logic wb_cyc_i,
	input  logic wb_stb_i,
	input  logic wb_we_i,
	input  logic [6:0] wb_adr_i,
	input  logic [31:0] wb_dat_i,
	output logic [31:0] wb_dat_o,
	output logic wb_ack_o,
	input  logic [lab4d_pkg::NUM_LAB-1:0] readout_fifo_empty_i,
	lab4d_ctrl_if.regs ctrl,
	output logic [lab4d_pkg::SHIFT_PRESCALE_W-1:0] shift_prescale_o,
	output logic [lab4d_pkg::READOUT_PRESCALE_W-1:0] readout_prescale_o,
	output logic [lab4d_pkg::NUM_LAB-1:0] regclear_o,
	output logic readout_test_pattern_o,
	output logic readout_fifo_rst_o,
	output logic readout_rst_o,
	output logic readout_not_test_pattern_o,
	output logic [lab4d_pkg::EMPTY_SIZE_W-1:0] empty_size_o
);
	import lab4d_pkg::*;

	wb_reg_e adr_reg;
	logic ack_q;
	logic wb_wr;
	logic data_available;

	logic [NUM_LAB-1:0] regclear_q;
	logic test_pattern_q;
	logic [SHIFT_PRESCALE_W-1:0] shift_prescale_q;
	logic [READOUT_PRESCALE_W-1:0] readout_prescale_q;
	logic not_test_pattern_q;
	logic fifo_rst_q;
	logic readout_rst_q;
	logic [EMPTY_SIZE_W-1:0] empty_size_q;

	assign adr_reg = wb_reg_e'(wb_adr_i[6:2]);
	// one write per bus cycle, on the edge that raises ack
	assign wb_wr = wb_cyc_i && wb_stb_i && wb_we_i && !ack_q;
	assign data_available = ~&readout_fifo_empty_i;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= wb_cyc_i && wb_stb_i && !ack_q;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// control and user serial registers, shared with the sequencer
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			ctrl.reset_request <= 1'b0;
			ctrl.runmode_request <= 1'b0;
			regclear_q <= '0;
			test_pattern_q <= 1'b0;
			ctrl.user_write <= '0;
			ctrl.user_select <= '0;
			ctrl.user_write_request <= 1'b0;
		end else begin
			// sequencer write takes priority here
			if (ctrl.ctrl_wr) begin
				ctrl.reset_request <= ctrl.ctrl_reset_val;
			end else if (wb_wr && adr_reg == REG_CONTROL) begin
				ctrl.reset_request <= wb_dat_i[0];
			end
			if (wb_wr && adr_reg == REG_CONTROL) begin
				ctrl.runmode_request <= wb_dat_i[1];
				test_pattern_q <= wb_dat_i[15];
				regclear_q <= wb_dat_i[16 +: NUM_LAB];
			end
			// but the bus wins for the user request
			if (wb_wr && adr_reg == REG_USER_WRITE) begin
				ctrl.user_write <= wb_dat_i[SERIAL_W-1:0];
				ctrl.user_select <= wb_dat_i[24 +: SEL_W];
				ctrl.user_write_request <= wb_dat_i[31];
			end else if (ctrl.user_req_wr) begin
				ctrl.user_write_request <= ctrl.user_req_val;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// prescales and readout control
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			shift_prescale_q <= SHIFT_PRESCALE_DEFAULT;
			readout_prescale_q <= READOUT_PRESCALE_DEFAULT;
			not_test_pattern_q <= 1'b0;
			fifo_rst_q <= 1'b0;
			readout_rst_q <= 1'b0;
			empty_size_q <= '0;
		end else begin
			if (wb_wr && adr_reg == REG_SHIFT_PRESCALE) begin
				shift_prescale_q <= wb_dat_i[SHIFT_PRESCALE_W-1:0];
			end
			if (wb_wr && adr_reg == REG_READOUT_PRESCALE) begin
				readout_prescale_q <= wb_dat_i[READOUT_PRESCALE_W-1:0];
			end
			if (wb_wr && adr_reg == REG_READOUT) begin
				not_test_pattern_q <= wb_dat_i[4];
			end
			// single cycle resets
			fifo_rst_q <= wb_wr && adr_reg == REG_READOUT && wb_dat_i[1];
			readout_rst_q <= wb_wr && adr_reg == REG_READOUT && wb_dat_i[2];
			if (wb_wr && adr_reg == REG_EMPTY_SIZE) begin
				empty_size_q <= wb_dat_i[EMPTY_SIZE_W-1:0];
			end
		end
	end

	// read mux, unlisted words read zero
	always_comb begin
		wb_dat_o = '0;
		case (adr_reg)
			REG_CONTROL: begin
				wb_dat_o[0] = ctrl.reset_request;
				wb_dat_o[1] = ctrl.runmode_request;
				wb_dat_o[2] = ctrl.runmode;
				wb_dat_o[15] = test_pattern_q;
				wb_dat_o[16 +: NUM_LAB] = regclear_q;
			end
			REG_SHIFT_PRESCALE: wb_dat_o[SHIFT_PRESCALE_W-1:0] = shift_prescale_q;
			REG_READOUT_PRESCALE: wb_dat_o[READOUT_PRESCALE_W-1:0] = readout_prescale_q;
			REG_USER_WRITE: begin
				wb_dat_o[SERIAL_W-1:0] = ctrl.user_write;
				wb_dat_o[24 +: SEL_W] = ctrl.user_select;
				wb_dat_o[31] = ctrl.user_write_request;
			end
			REG_READOUT: begin
				wb_dat_o[0] = ctrl.readout_done;
				wb_dat_o[3] = data_available;
				wb_dat_o[4] = not_test_pattern_q;
				wb_dat_o[7] = ctrl.readout_pending;
				wb_dat_o[16 +: NUM_LAB] = readout_fifo_empty_i;
			end
			REG_EMPTY_SIZE: wb_dat_o[EMPTY_SIZE_W-1:0] = empty_size_q;
			default: wb_dat_o = '0;
		endcase
	end

	assign wb_ack_o = ack_q;
	assign shift_prescale_o = shift_prescale_q;
	assign readout_prescale_o = readout_prescale_q;
	assign regclear_o = regclear_q;
	assign readout_test_pattern_o = test_pattern_q;
	assign readout_fifo_rst_o = fifo_rst_q;
	assign readout_rst_o = readout_rst_q;
	assign readout_not_test_pattern_o = not_test_pattern_q;
	assign empty_size_o = empty_size_q;

endmodule

// File: hdl/lab4d_seq_ports.sv
module lab4d_seq_ports (
	input  logic clk_i,
	input  logic rst_n_i,
	input  logic [7:0] pb_port_i,
	input  logic [7:0] pb_out_i,
	input  logic pb_write_i,
	output logic [7:0] pb_in_o,
	input  logic complete_i,
	output logic readout_o,
	lab4d_ctrl_if.seq ctrl,
	lab4d_serial_if.loader ser
);
	import lab4d_pkg::*;

	pb_port_e wr_port;
	pb_port_e rd_port;
	logic readout_req;
	logic readout_q;

	// fold read aliases onto their base port
	function automatic pb_port_e base_port(input logic [4:0] p);
		logic [4:0] q;
		q = p;
		if (p[4:3] == 2'b11) begin
			q[3] = 1'b0;
		end else if (p[4:2] == 3'b011) begin
			q[2] = 1'b0;
		end else if (p[4:2] == 3'b000) begin
			q[1:0] = 2'b00;
		end
		return pb_port_e'(q);
	endfunction

	assign wr_port = pb_port_e'(pb_port_i[4:0]);
	assign rd_port = base_port(pb_port_i[4:0]);
	assign readout_req = pb_write_i && wr_port == PORT_READOUT && pb_out_i[6];

	// strobes into the register slave
	assign ctrl.ctrl_wr = pb_write_i && wr_port == PORT_CONTROL;
	assign ctrl.ctrl_reset_val = pb_out_i[0];
	assign ctrl.user_req_wr = pb_write_i && wr_port == PORT_USER_WRITE3;
	assign ctrl.user_req_val = pb_out_i[7];

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			ctrl.runmode <= 1'b0;
			ser.word <= '0;
			ser.select <= '0;
			ser.go <= 1'b0;
			ctrl.readout_done <= 1'b0;
		end else begin
			ser.go <= 1'b0;
			if (pb_write_i) begin
				case (wr_port)
					PORT_CONTROL: ctrl.runmode <= pb_out_i[2];
					PORT_SERIAL0: ser.word[7:0] <= pb_out_i;
					PORT_SERIAL1: ser.word[15:8] <= pb_out_i;
					PORT_SERIAL2: ser.word[23:16] <= pb_out_i;
					PORT_SERIAL_CTRL: begin
						ser.select <= pb_out_i[SEL_W-1:0];
						// go one cycle later so word and select are settled
						ser.go <= pb_out_i[6];
					end
					PORT_READOUT: ctrl.readout_done <= pb_out_i[0];
					default: ;
				endcase
			end
		end
	end

	// readout request, ignored while one is pending
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			ctrl.readout_pending <= 1'b0;
			readout_q <= 1'b0;
		end else begin
			readout_q <= readout_req && !ctrl.readout_pending;
			if (complete_i) begin
				ctrl.readout_pending <= 1'b0;
			end else if (readout_req) begin
				ctrl.readout_pending <= 1'b1;
			end
		end
	end

	assign readout_o = readout_q;

	always_comb begin
		pb_in_o = '0;
		case (rd_port)
			PORT_CONTROL: pb_in_o[2:0] = {ctrl.runmode, ctrl.runmode_request, ctrl.reset_request};
			PORT_USER_WRITE0: pb_in_o = ctrl.user_write[7:0];
			PORT_USER_WRITE1: pb_in_o = ctrl.user_write[15:8];
			PORT_USER_WRITE2: pb_in_o = ctrl.user_write[23:16];
			PORT_USER_WRITE3: begin
				pb_in_o[SEL_W-1:0] = ctrl.user_select;
				pb_in_o[7] = ctrl.user_write_request;
			end
			PORT_SERIAL0: pb_in_o = ser.word[7:0];
			PORT_SERIAL1: pb_in_o = ser.word[15:8];
			PORT_SERIAL2: pb_in_o = ser.word[23:16];
			PORT_SERIAL_CTRL: begin
				pb_in_o[SEL_W-1:0] = ser.select;
				pb_in_o[7] = ser.busy;
			end
			PORT_READOUT: begin
				pb_in_o[0] = ctrl.readout_done;
				pb_in_o[7] = ctrl.readout_pending;
			end
			default: pb_in_o = '0;
		endcase
	end

endmodule

// File: hdl/lab4d_serial_shift.sv
module lab4d_serial_shift (
	input  logic clk_i,
	input  logic rst_n_i,
	input  logic [lab4d_pkg::SHIFT_PRESCALE_W-1:0] prescale_i,
	lab4d_serial_if.shifter ser,
	output logic [lab4d_pkg::NUM_LAB-1:0] sin_o,
	output logic [lab4d_pkg::NUM_LAB-1:0] sclk_o,
	output logic [lab4d_pkg::NUM_LAB-1:0] pclk_o
);
	import lab4d_pkg::*;

	shift_state_e state_q;
	logic [SHIFT_PRESCALE_W-1:0] presc_q;
	logic [SHIFT_PRESCALE_W-1:0] cnt_q;
	logic [SERIAL_CNT_W-1:0] bit_q;
	logic [SERIAL_W-1:0] word_q;
	logic [NUM_LAB-1:0] mask_q;
	logic start;
	logic phase_end;

	// selects past the last chip are broadcast
	function automatic logic [NUM_LAB-1:0] chip_mask(input logic [SEL_W-1:0] sel);
		if (sel >= SEL_W'(NUM_LAB)) begin
			return '1;
		end
		return NUM_LAB'(1) << sel;
	endfunction

	assign start = ser.go && state_q == IDLE;
	// every state phase lasts prescale+1 cycles
	assign phase_end = (cnt_q == presc_q);

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state_q <= IDLE;
			cnt_q <= '0;
			bit_q <= '0;
		end else begin
			cnt_q <= (start || phase_end) ? '0 : cnt_q + 1'b1;
			case (state_q)
				IDLE: begin
					if (ser.go) begin
						state_q <= DATA_LOW;
						bit_q <= SERIAL_CNT_W'(SERIAL_W - 1);
					end
				end
				DATA_LOW: if (phase_end) state_q <= DATA_HIGH;
				DATA_HIGH: begin
					if (phase_end) begin
						state_q <= (bit_q == '0) ? LOAD : DATA_LOW;
						bit_q <= bit_q - 1'b1;
					end
				end
				LOAD: if (phase_end) state_q <= IDLE;
				default: state_q <= IDLE;
			endcase
		end
	end

	// word, mask and prescale held for the whole transfer
	always_ff @(posedge clk_i) begin
		if (start) begin
			word_q <= ser.word;
			mask_q <= chip_mask(ser.select);
			presc_q <= prescale_i;
		end else if (state_q == DATA_HIGH && phase_end) begin
			word_q <= {word_q[SERIAL_W-2:0], 1'b0};
		end
	end

	assign ser.busy = (state_q != IDLE);

	// msb first, only the selected chips toggle
	always_comb begin
		sin_o = '0;
		sclk_o = '0;
		pclk_o = '0;
		case (state_q)
			DATA_LOW: sin_o = mask_q & {NUM_LAB{word_q[SERIAL_W-1]}};
			DATA_HIGH: begin
				sin_o = mask_q & {NUM_LAB{word_q[SERIAL_W-1]}};
				sclk_o = mask_q;
			end
			LOAD: pclk_o = mask_q;
			default: ;
		endcase
	end

endmodule

// File: hdl/lab4d_controller.sv
module lab4d_controller (
	input  logic clk_i,
	input  logic rst_n_i,
	input  logic wb_cyc_i,
	input  logic wb_stb_i,
	input  logic wb_we_i,
	input  logic [6:0] wb_adr_i,
	input  logic [31:0] wb_dat_i,
	output logic [31:0] wb_dat_o,
	output logic wb_ack_o,
	input  logic [7:0] pb_port_i,
	input  logic [7:0] pb_out_i,
	input  logic pb_write_i,
	output logic [7:0] pb_in_o,
	input  logic [lab4d_pkg::NUM_LAB-1:0] readout_fifo_empty_i,
	input  logic complete_i,
	output logic readout_o,
	output logic readout_test_pattern_o,
	output logic readout_fifo_rst_o,
	output logic readout_rst_o,
	output logic [lab4d_pkg::EMPTY_SIZE_W-1:0] readout_empty_size_o,
	output logic [lab4d_pkg::READOUT_PRESCALE_W-1:0] prescale_o,
	output logic [lab4d_pkg::NUM_LAB-1:0] sin_o,
	output logic [lab4d_pkg::NUM_LAB-1:0] sclk_o,
	output logic [lab4d_pkg::NUM_LAB-1:0] pclk_o,
	output logic [lab4d_pkg::NUM_LAB-1:0] regclr_o
);
	import lab4d_pkg::*;

	logic [SHIFT_PRESCALE_W-1:0] shift_prescale;

	lab4d_ctrl_if ctrl_if ();
	lab4d_serial_if ser_if ();

	// bus side registers
	lab4d_wb_regs u_wb_regs (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.wb_cyc_i(wb_cyc_i),
		.wb_stb_i(wb_stb_i),
		.wb_we_i(wb_we_i),
		.wb_adr_i(wb_adr_i),
		.wb_dat_i(wb_dat_i),
		.wb_dat_o(wb_dat_o),
		.wb_ack_o(wb_ack_o),
		.readout_fifo_empty_i(readout_fifo_empty_i),
		.ctrl(ctrl_if.regs),
		.shift_prescale_o(shift_prescale),
		.readout_prescale_o(prescale_o),
		.regclear_o(regclr_o),
		.readout_test_pattern_o(readout_test_pattern_o),
		.readout_fifo_rst_o(readout_fifo_rst_o),
		.readout_rst_o(readout_rst_o),
		.readout_not_test_pattern_o(),
		.empty_size_o(readout_empty_size_o)
	);

	lab4d_seq_ports u_seq_ports (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.pb_port_i(pb_port_i),
		.pb_out_i(pb_out_i),
		.pb_write_i(pb_write_i),
		.pb_in_o(pb_in_o),
		.complete_i(complete_i),
		.readout_o(readout_o),
		.ctrl(ctrl_if.seq),
		.ser(ser_if.loader)
	);

	lab4d_serial_shift u_serial_shift (
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.prescale_i(shift_prescale),
		.ser(ser_if.shifter),
		.sin_o(sin_o),
		.sclk_o(sclk_o),
		.pclk_o(pclk_o)
	);

endmodule

// File: tests/lab4d_serial_assert.sv
module lab4d_serial_assert (
	input  logic clk_i,
	input  logic rst_n_i,
	input  logic go_i,
	input  logic busy_i,
	input  logic [lab4d_pkg::SHIFT_PRESCALE_W-1:0] presc_i,
	input  logic [lab4d_pkg::NUM_LAB-1:0] mask_i,
	input  logic [lab4d_pkg::NUM_LAB-1:0] sin_i,
	input  logic [lab4d_pkg::NUM_LAB-1:0] sclk_i,
	input  logic [lab4d_pkg::NUM_LAB-1:0] pclk_i
);
	timeunit 1ns;
	timeprecision 100ps;
	import lab4d_pkg::*;

	int busy_len;

	// length of the current busy period
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			busy_len <= 0;
		end else if (busy_i) begin
			busy_len <= busy_len + 1;
		end else begin
			busy_len <= 0;
		end
	end

	// a go during a transfer leaves the latched setup alone
	go_ignored_when_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		go_i && busy_i |=> $stable(mask_i) && $stable(presc_i))
		else $error("shifter accepted go while busy");

	sclk_pclk_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!((|sclk_i) && (|pclk_i)))
		else $error("sclk and pclk high together");

	busy_length: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		$fell(busy_i) |-> busy_len == 49 * (int'(presc_i) + 1))
		else $error("busy lasted %0d cycles", busy_len);

	unselected_low: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		((sin_i | sclk_i | pclk_i) & ~mask_i) == '0)
		else $error("unselected chip line toggled");

endmodule

bind lab4d_serial_shift lab4d_serial_assert u_serial_assert (
	.clk_i(clk_i),
	.rst_n_i(rst_n_i),
	.go_i(ser.go),
	.busy_i(ser.busy),
	.presc_i(presc_q),
	.mask_i(mask_q),
	.sin_i(sin_o),
	.sclk_i(sclk_o),
	.pclk_i(pclk_o)
);

// File: tests/tb_lab4d_controller.sv
module tb_lab4d_controller;
	timeunit 1ns;
	timeprecision 100ps;

	// prescale of each shift, sum of prescale+1 over the table is 24
	localparam int NUM_SHIFTS = 8;
	localparam logic [63:0] SHIFT_PRESCALES =
		{8'd2, 8'd7, 8'd1, 8'd0, 8'd3, 8'd2, 8'd1, 8'd0};

	logic clk_i = 1'b0;
	logic rst_n_i;
	logic wb_cyc_i, wb_stb_i, wb_we_i;
	logic [6:0] wb_adr_i;
	logic [31:0] wb_dat_i, wb_dat_o;
	logic wb_ack_o;
	logic [7:0] pb_port_i, pb_out_i, pb_in_o;
	logic pb_write_i;
	logic [11:0] readout_fifo_empty_i;
	logic complete_i;
	logic readout_o, readout_test_pattern_o, readout_fifo_rst_o, readout_rst_o;
	logic [9:0] readout_empty_size_o;
	logic [3:0] prescale_o;
	logic [11:0] sin_o, sclk_o, pclk_o, regclr_o;

	int errors = 0;
	int checks = 0;
	int tests = 0;
	int tests_passed = 0;
	int test_err0;
	int cycles = 0;
	int cycle_limit;
	logic [31:0] lcg_state = 32'h43c755d6;

	// shift monitor state
	logic mon_active = 1'b0;
	logic [23:0] exp_seq;
	logic [11:0] exp_mask = '0;
	logic [11:0] prev_sclk = '0;
	logic [11:0] prev_pclk = '0;
	int bits_seen;
	int pclk_pulses;
	int readout_pulses = 0;
	int fifo_rst_pulses = 0;
	int rst_pulses = 0;

	lab4d_controller dut (.*);

	always #50 clk_i = ~clk_i;

	always @(posedge clk_i) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("timeout, run stopped after %0d cycles", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// bits in send order (msb first) and the chip mask of a select
	function automatic logic [35:0] expected_shift(input logic [23:0] word,
			input logic [3:0] sel);
		logic [23:0] seq;
		logic [11:0] mask;
		for (int i = 0; i < 24; i++) begin
			seq[i] = word[23 - i];
		end
		if (sel >= 4'd12) begin
			mask = '1;
		end else begin
			mask = 12'd1 << sel;
		end
		return {mask, seq};
	endfunction

	function automatic logic [31:0] readout_word(input logic done, input logic pending,
			input logic ntp, input logic [11:0] empty);
		logic [31:0] w;
		w = '0;
		w[0] = done;
		w[3] = |(~empty);
		w[4] = ntp;
		w[7] = pending;
		w[27:16] = empty;
		return w;
	endfunction

	function automatic logic word_used(input int w);
		case (w)
			0, 1, 2, 6, 22, 23: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	task automatic check_equal(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %t %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic start_test();
		test_err0 = errors;
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors == test_err0) begin
			tests_passed++;
			$display("test %0d %s: passed", tests, name);
		end else begin
			$display("test %0d %s: failed with %0d errors", tests, name, errors - test_err0);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// bus tasks, called at a falling edge and returning at one
	////////////////////////////////////////////////////////////////////////////

	task automatic wb_access(input logic we, input int word_idx, input logic [31:0] data,
			output logic [31:0] rdata);
		int n;
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i = we;
		wb_adr_i = {word_idx[4:0], 2'b00};
		wb_dat_i = data;
		n = 0;
		do begin
			@(negedge clk_i);
			n++;
		end while (!wb_ack_o && n < 8);
		if (!wb_ack_o) begin
			errors++;
			$display("wishbone access to word %0d got no ack", word_idx);
		end
		rdata = wb_dat_o;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
	endtask

	task automatic wb_write(input int word_idx, input logic [31:0] data);
		logic [31:0] unused;
		wb_access(1'b1, word_idx, data, unused);
	endtask

	task automatic wb_read(input int word_idx, output logic [31:0] data);
		wb_access(1'b0, word_idx, 32'h0, data);
	endtask

	task automatic pb_write(input logic [7:0] port, input logic [7:0] data);
		pb_port_i = port;
		pb_out_i = data;
		pb_write_i = 1'b1;
		@(negedge clk_i);
		pb_write_i = 1'b0;
	endtask

	task automatic pb_read(input logic [7:0] port, output logic [7:0] data);
		pb_port_i = port;
		@(negedge clk_i);
		data = pb_in_o;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// serial monitor, compares sin at each rise of the selected sclk
	////////////////////////////////////////////////////////////////////////////

	always @(negedge clk_i) begin
		if (rst_n_i && mon_active) begin
			if (((sin_o | sclk_o | pclk_o) & ~exp_mask) != '0) begin
				errors++;
				$display("[ERROR] %t unselected lines: got %h, expected 000", $time,
					(sin_o | sclk_o | pclk_o) & ~exp_mask);
			end
			if (sclk_o != '0 && prev_sclk == '0) begin
				check_equal("sclk_o", sclk_o, exp_mask);
				if (bits_seen >= 24) begin
					errors++;
					$display("more than 24 sclk rises in one transfer");
				end else begin
					check_equal("sin_o", sin_o, exp_seq[bits_seen] ? exp_mask : 12'h0);
				end
				bits_seen++;
			end
			if (pclk_o != '0 && prev_pclk == '0) begin
				check_equal("pclk_o", pclk_o, exp_mask);
				pclk_pulses++;
			end
		end else if (rst_n_i && (sin_o | sclk_o | pclk_o) != '0) begin
			errors++;
			$display("[ERROR] %t serial lines: got %h, expected 000", $time,
				sin_o | sclk_o | pclk_o);
		end
		prev_sclk = sclk_o;
		prev_pclk = pclk_o;
	end

	// pulse widths in cycles
	always @(negedge clk_i) begin
		if (rst_n_i) begin
			readout_pulses += readout_o;
			fifo_rst_pulses += readout_fifo_rst_o;
			rst_pulses += readout_rst_o;
		end
	end

	task automatic run_shift(input logic [7:0] p, input logic [23:0] word,
			input logic [3:0] sel);
		logic [35:0] r;
		logic [31:0] rd;
		logic [7:0] rd8;
		int wait_n;
		int busy_n;
		int expect_n;
		r = expected_shift(word, sel);
		exp_mask = r[35:24];
		exp_seq = r[23:0];
		bits_seen = 0;
		pclk_pulses = 0;
		expect_n = 49 * (int'(p) + 1);
		wb_write(1, {24'h0, p});
		wb_read(1, rd);
		check_equal("wb_dat_o word 1", rd, {24'h0, p});
		pb_write(8'd16, word[7:0]);
		pb_write(8'd17, word[15:8]);
		pb_write(8'd18, word[23:16]);
		mon_active = 1'b1;
		pb_write(8'd19, {4'b0100, sel});
		wait_n = 0;
		while (!pb_in_o[7] && wait_n < 4) begin
			@(negedge clk_i);
			wait_n++;
		end
		if (!pb_in_o[7]) begin
			errors++;
			$display("busy never rose on port 19");
		end
		busy_n = 0;
		while (pb_in_o[7] && busy_n <= expect_n) begin
			busy_n++;
			if (busy_n == 3) begin
				// second go with another chip mask, mid transfer
				pb_write(8'd19, {4'b0100, sel ^ 4'h8});
			end else begin
				@(negedge clk_i);
			end
		end
		mon_active = 1'b0;
		check_equal("busy cycles", busy_n, expect_n);
		check_equal("sclk rises", bits_seen, 24);
		check_equal("pclk pulses", pclk_pulses, 1);
		pb_read(8'd27, rd8);
		check_equal("pb_in_o port 27", rd8, {4'h0, sel ^ 4'h8});
		pb_read(8'd24, rd8);
		check_equal("pb_in_o port 24", rd8, word[7:0]);
		pb_read(8'd18, rd8);
		check_equal("pb_in_o port 18", rd8, word[23:16]);
	endtask

	initial begin
		logic [31:0] rd;
		logic [7:0] rd8;
		logic [31:0] r;
		logic [3:0] sel;
		logic [7:0] p;
		$timeformat(-9, 1, " ns", 0);
		cycle_limit = 3000;
		for (int i = 0; i < NUM_SHIFTS; i++) begin
			cycle_limit += 49 * (int'(SHIFT_PRESCALES[i*8 +: 8]) + 1);
		end
		rst_n_i = 1'b0;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		wb_adr_i = '0;
		wb_dat_i = '0;
		pb_port_i = '0;
		pb_out_i = '0;
		pb_write_i = 1'b0;
		readout_fifo_empty_i = '1;
		complete_i = 1'b0;
		repeat (5) @(negedge clk_i);
		rst_n_i = 1'b1;
		@(negedge clk_i);

		start_test();
		for (int w = 0; w < 32; w++) begin
			if (word_used(w)) begin
				wb_read(w, rd);
				check_equal($sformatf("wb_dat_o word %0d", w), rd,
					w == 22 ? readout_word(0, 0, 0, 12'hFFF) : 32'h0);
			end
		end
		wb_write(1, 32'hFFFF_FF5A);
		wb_write(2, 32'hFFFF_FFF9);
		wb_write(0, 32'h0A5C_8000);
		wb_write(23, 32'hFFFF_F2AB);
		wb_read(1, rd);
		check_equal("wb_dat_o word 1", rd, 32'h5A);
		wb_read(2, rd);
		check_equal("wb_dat_o word 2", rd, 32'h9);
		wb_read(0, rd);
		check_equal("wb_dat_o word 0", rd, 32'h0A5C_8000);
		wb_read(23, rd);
		check_equal("wb_dat_o word 23", rd, 32'h2AB);
		check_equal("prescale_o", prescale_o, 32'h9);
		check_equal("regclr_o", regclr_o, 32'hA5C);
		check_equal("readout_test_pattern_o", readout_test_pattern_o, 32'h1);
		check_equal("readout_empty_size_o", readout_empty_size_o, 32'h2AB);
		for (int w = 0; w < 32; w++) begin
			if (!word_used(w)) begin
				wb_write(w, 32'hFFFF_FFFF);
				wb_read(w, rd);
				check_equal($sformatf("wb_dat_o word %0d", w), rd, 32'h0);
			end
		end
		wb_write(0, 32'h0);
		end_test("register defaults and readback");

		start_test();
		wb_write(6, 32'h8BC3_A51E);
		wb_read(6, rd);
		check_equal("wb_dat_o word 6", rd, 32'h8BC3_A51E);
		for (int k = 0; k < 8; k++) begin
			pb_read(8'(8 + k), rd8);
			check_equal($sformatf("pb_in_o port %0d", 8 + k), rd8,
				8'(32'h8BC3_A51E >> (8 * (k % 4))));
		end
		pb_write(8'd11, 8'h00);
		wb_read(6, rd);
		check_equal("wb_dat_o word 6", rd, 32'h0BC3_A51E);
		pb_read(8'd15, rd8);
		check_equal("pb_in_o port 15", rd8, 8'h0B);
		end_test("user write register and ports");

		start_test();
		pb_write(8'd0, 8'h05);
		wb_read(0, rd);
		check_equal("wb_dat_o word 0", rd, 32'h5);
		pb_read(8'd3, rd8);
		check_equal("pb_in_o port 3", rd8, 8'h05);
		wb_write(0, 32'h2);
		wb_read(0, rd);
		check_equal("wb_dat_o word 0", rd, 32'h6);
		pb_write(8'd0, 8'h00);
		wb_read(0, rd);
		check_equal("wb_dat_o word 0", rd, 32'h2);
		wb_write(0, 32'h0);
		end_test("sequencer control port");

		start_test();
		for (int i = 0; i < NUM_SHIFTS; i++) begin
			p = SHIFT_PRESCALES[i*8 +: 8];
			r = next_random();
			sel = next_random() >> 7;
			// force both broadcast ends into the mix
			if (i == 3) begin
				sel = 4'd15;
			end else if (i == 6) begin
				sel = 4'd12;
			end
			run_shift(p, r[23:0], sel);
		end
		end_test("serial shifts");

		start_test();
		readout_fifo_empty_i = 12'hFF7;
		pb_write(8'd22, 8'h40);
		wb_read(22, rd);
		check_equal("wb_dat_o word 22", rd, readout_word(0, 1, 0, 12'hFF7));
		check_equal("readout_o cycles", readout_pulses, 1);
		pb_write(8'd22, 8'h41);
		wb_read(22, rd);
		check_equal("wb_dat_o word 22", rd, readout_word(1, 1, 0, 12'hFF7));
		check_equal("readout_o cycles", readout_pulses, 1);
		complete_i = 1'b1;
		@(negedge clk_i);
		complete_i = 1'b0;
		wb_read(22, rd);
		check_equal("wb_dat_o word 22", rd, readout_word(1, 0, 0, 12'hFF7));
		pb_read(8'd30, rd8);
		check_equal("pb_in_o port 30", rd8, 8'h01);
		readout_fifo_empty_i = '1;
		wb_read(22, rd);
		check_equal("wb_dat_o word 22", rd, readout_word(1, 0, 0, 12'hFFF));
		// complete in the same cycle as a request keeps pending low
		complete_i = 1'b1;
		pb_write(8'd22, 8'h40);
		complete_i = 1'b0;
		wb_read(22, rd);
		check_equal("wb_dat_o word 22", rd, readout_word(0, 0, 0, 12'hFFF));
		wb_write(22, 32'h16);
		repeat (2) @(negedge clk_i);
		check_equal("readout_fifo_rst_o cycles", fifo_rst_pulses, 1);
		check_equal("readout_rst_o cycles", rst_pulses, 1);
		check_equal("readout_o cycles", readout_pulses, 2);
		wb_read(22, rd);
		check_equal("wb_dat_o word 22", rd, readout_word(0, 0, 1, 12'hFFF));
		end_test("readout request and resets");

		$display("tests passed %0d of %0d, checks %0d, errors %0d",
			tests_passed, tests, checks, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: compile.f
hdl/lab4d_pkg.sv
hdl/lab4d_ctrl_if.sv
hdl/lab4d_serial_if.sv
hdl/lab4d_wb_regs.sv
hdl/lab4d_seq_ports.sv
hdl/lab4d_serial_shift.sv
hdl/lab4d_controller.sv
tests/lab4d_serial_assert.sv
tests/tb_lab4d_controller.sv

// File: Bender.yml
package:
  name: lab4d_controller

sources:
  - hdl/lab4d_pkg.sv
  - hdl/lab4d_ctrl_if.sv
  - hdl/lab4d_serial_if.sv
  - hdl/lab4d_wb_regs.sv
  - hdl/lab4d_seq_ports.sv
  - hdl/lab4d_serial_shift.sv
  - hdl/lab4d_controller.sv
  - target: test
    files:
      - tests/lab4d_serial_assert.sv
      - tests/tb_lab4d_controller.sv
